// File: Makefile
TOP = tb_top_mips

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f top_mips.f --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: rtl/alu_execute.sv
module alu_execute (
    input  mips_pkg::id_ex_t   i_id_ex,
    input  mips_pkg::fwd_sel_t i_fwd_a,
    input  mips_pkg::fwd_sel_t i_fwd_b,
    input  mips_pkg::word_t    i_mem_fwd,
    input  mips_pkg::word_t    i_wb_fwd,
    output mips_pkg::ex_mem_t  o_ex_mem
);

    mips_pkg::word_t op_a;
    mips_pkg::word_t op_b_reg;
    mips_pkg::word_t op_b;
    mips_pkg::word_t result;

    function automatic mips_pkg::word_t select_operand(
        input mips_pkg::fwd_sel_t sel,
        input mips_pkg::word_t    reg_val,
        input mips_pkg::word_t    mem_val,
        input mips_pkg::word_t    wb_val
    );
        case (sel)
            mips_pkg::FWD_MEM: return mem_val;
            mips_pkg::FWD_WB:  return wb_val;
            default:           return reg_val;
        endcase
    endfunction

    // ----------------------------------------
    // Operand selection
    // ----------------------------------------
    assign op_a     = select_operand(i_fwd_a, i_id_ex.rs_data, i_mem_fwd, i_wb_fwd);
    assign op_b_reg = select_operand(i_fwd_b, i_id_ex.rt_data, i_mem_fwd, i_wb_fwd);
    assign op_b     = i_id_ex.ctrl.alu_src ? i_id_ex.imm : op_b_reg;

    // ALU
    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            mips_pkg::ALU_ADD: result = op_a + op_b;
            mips_pkg::ALU_SUB: result = op_a - op_b;
            mips_pkg::ALU_AND: result = op_a & op_b;
            mips_pkg::ALU_OR:  result = op_a | op_b;
            mips_pkg::ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:           result = '0;
        endcase
    end

    // ----------------------------------------
    // Next EX/MEM contents
    // ----------------------------------------
    assign o_ex_mem.ctrl          = i_id_ex.ctrl;
    // Word offset relative to the delay slot address
    assign o_ex_mem.branch_target = i_id_ex.pc + 32'd4 + {i_id_ex.imm[29:0], 2'b00};
    assign o_ex_mem.zero          = (result == '0);
    assign o_ex_mem.alu_result    = result;
    assign o_ex_mem.store_data    = op_b_reg;
    assign o_ex_mem.dest          = i_id_ex.dest;

endmodule

// File: rtl/data_memory.sv
module data_memory #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic            i_clk,
    input  logic            i_we,
    input  mips_pkg::word_t i_addr,
    input  mips_pkg::word_t i_wdata,
    output mips_pkg::word_t o_rdata
);

    localparam int ADDR_W = $clog2(DMEM_DEPTH);

    mips_pkg::word_t      mem [DMEM_DEPTH];
    logic [ADDR_W-1:0]    index;

    // Word index from the byte address, upper bits wrap
    assign index = i_addr[ADDR_W+1:2];

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[index] <= i_wdata;
        end
    end

    // Read is asynchronous
    assign o_rdata = mem[index];

endmodule

// File: rtl/instr_fetch.sv
module instr_fetch #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_imem_we,
    input  mips_pkg::word_t  i_imem_addr,
    input  mips_pkg::word_t  i_imem_data,
    input  logic             i_pc_src,
    input  mips_pkg::word_t  i_branch_target,
    input  logic             i_flush,
    output mips_pkg::if_id_t o_if_id
);

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    mips_pkg::word_t imem [IMEM_DEPTH];
    mips_pkg::word_t pc;
    mips_pkg::word_t pc_next;
    mips_pkg::word_t fetched;

    // Both the write port and the PC use byte addresses, low two bits dropped
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr[IDX_W+1:2]] <= i_imem_data;
        end
    end

    assign pc_next = i_pc_src ? i_branch_target : pc + 32'd4;
    assign fetched = imem[pc[IDX_W+1:2]];

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // Fetch register, slot squashed on a taken branch
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_if_id.valid <= 1'b0;
        end else begin
            o_if_id.valid <= !i_flush;
            o_if_id.pc    <= pc;
            o_if_id.instr <= fetched;
        end
    end

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            funct_t;
    typedef logic [2:0]            alu_op_t;
    typedef logic [1:0]            fwd_sel_t;

    // ----------------------------------------
    // Instruction encodings
    // ----------------------------------------
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_BEQ   = 6'h04;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    // ALU operations
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    // Operand sources for the execute stage
    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    // ----------------------------------------
    // Pipeline registers
    // ----------------------------------------
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     branch_target;
        logic      zero;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     read_data;
        word_t     alu_result;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

// File: rtl/pipe_control.sv
module pipe_control (
    input  mips_pkg::if_id_t   i_if_id,
    input  mips_pkg::id_ex_t   i_id_ex,
    input  mips_pkg::ex_mem_t  i_ex_mem,
    input  mips_pkg::mem_wb_t  i_mem_wb,
    output mips_pkg::ctrl_t    o_ctrl,
    output mips_pkg::word_t    o_imm,
    output mips_pkg::reg_addr_t o_rs,
    output mips_pkg::reg_addr_t o_rt,
    output mips_pkg::reg_addr_t o_dest,
    output mips_pkg::fwd_sel_t o_fwd_a,
    output mips_pkg::fwd_sel_t o_fwd_b,
    output logic               o_pc_src,
    output logic               o_flush
);

    mips_pkg::opcode_t   opcode;
    mips_pkg::funct_t    funct;
    mips_pkg::reg_addr_t rd;

    // Forwarding source for one operand, memory stage first
    function automatic mips_pkg::fwd_sel_t pick_fwd(
        input mips_pkg::reg_addr_t src,
        input logic                mem_we,
        input mips_pkg::reg_addr_t mem_dest,
        input logic                wb_we,
        input mips_pkg::reg_addr_t wb_dest
    );
        if (src == '0) begin
            return mips_pkg::FWD_REG;
        end
        if (mem_we && mem_dest == src) begin
            return mips_pkg::FWD_MEM;
        end
        if (wb_we && wb_dest == src) begin
            return mips_pkg::FWD_WB;
        end
        return mips_pkg::FWD_REG;
    endfunction

    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------
    assign opcode = i_if_id.instr[31:26];
    assign o_rs   = i_if_id.instr[25:21];
    assign o_rt   = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign funct  = i_if_id.instr[5:0];
    assign o_imm  = {{16{i_if_id.instr[15]}}, i_if_id.instr[15:0]};

    // R-type writes rd, everything else targets rt
    assign o_dest = (opcode == mips_pkg::OP_RTYPE) ? rd : o_rt;

    // ----------------------------------------
    // Decoder
    // ----------------------------------------
    always_comb begin
        o_ctrl = '0;
        if (i_if_id.valid) begin
            case (opcode)
                mips_pkg::OP_RTYPE: begin
                    o_ctrl.reg_write = 1'b1;
                    case (funct)
                        mips_pkg::FN_ADD: o_ctrl.alu_op = mips_pkg::ALU_ADD;
                        mips_pkg::FN_SUB: o_ctrl.alu_op = mips_pkg::ALU_SUB;
                        mips_pkg::FN_AND: o_ctrl.alu_op = mips_pkg::ALU_AND;
                        mips_pkg::FN_OR:  o_ctrl.alu_op = mips_pkg::ALU_OR;
                        mips_pkg::FN_SLT: o_ctrl.alu_op = mips_pkg::ALU_SLT;
                        default:          o_ctrl.reg_write = 1'b0;
                    endcase
                end
                mips_pkg::OP_ADDI: begin
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.alu_src   = 1'b1;
                    o_ctrl.alu_op    = mips_pkg::ALU_ADD;
                end
                mips_pkg::OP_LW: begin
                    o_ctrl.reg_write  = 1'b1;
                    o_ctrl.mem_to_reg = 1'b1;
                    o_ctrl.mem_read   = 1'b1;
                    o_ctrl.alu_src    = 1'b1;
                    o_ctrl.alu_op     = mips_pkg::ALU_ADD;
                end
                mips_pkg::OP_SW: begin
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.alu_src   = 1'b1;
                    o_ctrl.alu_op    = mips_pkg::ALU_ADD;
                end
                mips_pkg::OP_BEQ: begin
                    o_ctrl.branch = 1'b1;
                    o_ctrl.alu_op = mips_pkg::ALU_SUB;
                end
                default: o_ctrl = '0;
            endcase
        end
    end

    // ----------------------------------------
    // Forwarding and branch redirect
    // ----------------------------------------
    assign o_fwd_a = pick_fwd(i_id_ex.rs, i_ex_mem.ctrl.reg_write, i_ex_mem.dest,
                              i_mem_wb.reg_write, i_mem_wb.dest);
    assign o_fwd_b = pick_fwd(i_id_ex.rt, i_ex_mem.ctrl.reg_write, i_ex_mem.dest,
                              i_mem_wb.reg_write, i_mem_wb.dest);

    // BEQ resolves in the memory stage
    assign o_pc_src = i_ex_mem.ctrl.branch && i_ex_mem.zero;
    assign o_flush  = o_pc_src;

endmodule

// File: rtl/reg_file.sv
module reg_file (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_we,
    input  mips_pkg::reg_addr_t i_waddr,
    input  mips_pkg::word_t     i_wdata,
    input  mips_pkg::reg_addr_t i_raddr_a,
    input  mips_pkg::reg_addr_t i_raddr_b,
    output mips_pkg::word_t     o_rdata_a,
    output mips_pkg::word_t     o_rdata_b
);

    mips_pkg::word_t regs [32];
    logic            wr_live;

    // Register zero is never written and stays at its reset value
    assign wr_live = i_we && (i_waddr != '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Write-through so decode sees the writeback of the same cycle
    assign o_rdata_a = (wr_live && i_waddr == i_raddr_a) ? i_wdata : regs[i_raddr_a];
    assign o_rdata_b = (wr_live && i_waddr == i_raddr_b) ? i_wdata : regs[i_raddr_b];

endmodule

// File: rtl/top_mips.sv
module top_mips #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_imem_we,
    input  mips_pkg::word_t     i_imem_addr,
    input  mips_pkg::word_t     i_imem_data,
    output logic                o_wb_valid,
    output mips_pkg::reg_addr_t o_wb_reg,
    output mips_pkg::word_t     o_wb_data
);

    // ----------------------------------------
    // Pipeline registers and stage outputs
    // ----------------------------------------
    mips_pkg::if_id_t    if_id;
    mips_pkg::id_ex_t    id_ex;
    mips_pkg::id_ex_t    id_ex_next;
    mips_pkg::ex_mem_t   ex_mem;
    mips_pkg::ex_mem_t   ex_mem_next;
    mips_pkg::mem_wb_t   mem_wb;
    mips_pkg::mem_wb_t   mem_wb_next;

    // Decode
    mips_pkg::ctrl_t     dec_ctrl;
    mips_pkg::word_t     dec_imm;
    mips_pkg::reg_addr_t dec_rs;
    mips_pkg::reg_addr_t dec_rt;
    mips_pkg::reg_addr_t dec_dest;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;

    // Hazard and redirect
    mips_pkg::fwd_sel_t  fwd_a;
    mips_pkg::fwd_sel_t  fwd_b;
    logic                pc_src;
    logic                flush;

    mips_pkg::word_t     dmem_rdata;
    mips_pkg::word_t     wb_data;

    // ----------------------------------------
    // Fetch
    // ----------------------------------------
    instr_fetch #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_instr_fetch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .i_pc_src        (pc_src),
        .i_branch_target (ex_mem.branch_target),
        .i_flush         (flush),
        .o_if_id         (if_id)
    );

    // Decode, forwarding and branch control
    pipe_control u_pipe_control (
        .i_if_id  (if_id),
        .i_id_ex  (id_ex),
        .i_ex_mem (ex_mem),
        .i_mem_wb (mem_wb),
        .o_ctrl   (dec_ctrl),
        .o_imm    (dec_imm),
        .o_rs     (dec_rs),
        .o_rt     (dec_rt),
        .o_dest   (dec_dest),
        .o_fwd_a  (fwd_a),
        .o_fwd_b  (fwd_b),
        .o_pc_src (pc_src),
        .o_flush  (flush)
    );

    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (mem_wb.reg_write),
        .i_waddr   (mem_wb.dest),
        .i_wdata   (wb_data),
        .i_raddr_a (dec_rs),
        .i_raddr_b (dec_rt),
        .o_rdata_a (rs_data),
        .o_rdata_b (rt_data)
    );

    assign id_ex_next = '{ctrl: dec_ctrl, pc: if_id.pc, rs_data: rs_data,
                          rt_data: rt_data, imm: dec_imm, rs: dec_rs,
                          rt: dec_rt, dest: dec_dest};

    // ----------------------------------------
    // Execute and memory
    // ----------------------------------------
    alu_execute u_alu_execute (
        .i_id_ex   (id_ex),
        .i_fwd_a   (fwd_a),
        .i_fwd_b   (fwd_b),
        .i_mem_fwd (ex_mem.alu_result),
        .i_wb_fwd  (wb_data),
        .o_ex_mem  (ex_mem_next)
    );

    data_memory #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_data_memory (
        .i_clk   (i_clk),
        .i_we    (ex_mem.ctrl.mem_write),
        .i_addr  (ex_mem.alu_result),
        .i_wdata (ex_mem.store_data),
        .o_rdata (dmem_rdata)
    );

    assign mem_wb_next = '{reg_write: ex_mem.ctrl.reg_write,
                           mem_to_reg: ex_mem.ctrl.mem_to_reg,
                           read_data: ex_mem.ctrl.mem_read ? dmem_rdata : '0,
                           alu_result: ex_mem.alu_result, dest: ex_mem.dest};

    // Inter-stage registers, squash the two younger slots on a taken branch
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            id_ex.ctrl       <= '0;
            ex_mem.ctrl      <= '0;
            mem_wb.reg_write <= 1'b0;
        end else begin
            id_ex  <= id_ex_next;
            ex_mem <= ex_mem_next;
            mem_wb <= mem_wb_next;
            if (flush) begin
                id_ex.ctrl  <= '0;
                ex_mem.ctrl <= '0;
            end
        end
    end

    // ----------------------------------------
    // Writeback
    // ----------------------------------------
    assign wb_data    = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;
    assign o_wb_valid = mem_wb.reg_write && (mem_wb.dest != '0);
    assign o_wb_reg   = mem_wb.dest;
    assign o_wb_data  = wb_data;

endmodule

// File: tests/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// ----------------------------------------
// Galois LFSR, one step per bit
// ----------------------------------------
function automatic logic lfsr_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 16'hb400;
    end
    return out;
endfunction

function automatic mips_pkg::word_t rand_bits(int count);
    mips_pkg::word_t v;
    v = '0;
    for (int k = 0; k < count; k++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

// Reset stays low for the whole load, never shorter than RESET_CYCLES
task automatic reset_and_load();
    @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    for (int i = 0; i < IMEM_DEPTH || i < RESET_CYCLES; i++) begin
        i_imem_we   = (i < IMEM_DEPTH);
        i_imem_addr = mips_pkg::word_t'(i) << 2;
        if (i < prog.size()) begin
            i_imem_data = prog[i];
        end else begin
            i_imem_data = '0;
        end
        @(posedge i_clk);
        #1;
    end
    i_imem_we = 1'b0;
    i_rst     = 1'b1;
endtask

task automatic collect_writebacks();
    int cycles;
    for (int idx = 0; idx < exp_reg.size(); idx++) begin
        cycles = 0;
        @(negedge i_clk);
        while (!o_wb_valid && cycles < WAIT_CYCLES) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_wb_valid) begin
            $display("no writeback before timeout, %0d of %0d seen", idx, exp_reg.size());
            errors++;
            return;
        end
        check_reg("o_wb_reg", exp_reg[idx], o_wb_reg);
        check_word("o_wb_data", exp_data[idx], o_wb_data);
    end
endtask

task automatic expect_quiet(int cycles);
    repeat (cycles) begin
        @(negedge i_clk);
        if (o_wb_valid) begin
            $display("unexpected writeback to r%0d at %0t", o_wb_reg, $time);
            errors++;
        end
    end
endtask

task automatic run_program(string name);
    reset_and_load();
    run_model();
    collect_writebacks();
    expect_quiet(QUIET_CYCLES);
    if (errors == 0) begin
        pass_count++;
        $display("%-14s ok, %0d writebacks", name, exp_reg.size());
    end else begin
        fail_count++;
        $display("%-14s failed with %0d errors", name, errors);
    end
    errors = 0;
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------
// Empty program, the strobe must stay low
task automatic test_reset_quiet();
    prog.delete();
    run_program("reset_quiet");
endtask

task automatic test_alu_chain();
    prog.delete();
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'h1234));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd1, 16'hfffd));
    prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd3, 5'd1, 5'd2));
    prog.push_back(enc_r(mips_pkg::FN_SUB, 5'd4, 5'd3, 5'd1));
    prog.push_back(enc_r(mips_pkg::FN_AND, 5'd5, 5'd4, 5'd3));
    prog.push_back(enc_r(mips_pkg::FN_OR, 5'd6, 5'd5, 5'd2));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd9, 5'd0, 16'hfff9));
    prog.push_back(enc_r(mips_pkg::FN_SLT, 5'd7, 5'd9, 5'd6));
    prog.push_back(enc_r(mips_pkg::FN_SLT, 5'd8, 5'd6, 5'd9));
    prog.push_back(enc_r(mips_pkg::FN_SUB, 5'd10, 5'd9, 5'd7));
    run_program("alu_chain");
endtask

// Store, gap, load, filler, then use
task automatic test_load_store();
    prog.delete();
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'h8001));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'h0040));
    prog.push_back(enc_i(mips_pkg::OP_SW, 5'd1, 5'd2, 16'h0008));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd5, 5'd0, 16'h0001));
    prog.push_back(enc_i(mips_pkg::OP_LW, 5'd3, 5'd2, 16'h0008));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd6, 5'd0, 16'h0002));
    prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd4, 5'd3, 5'd1));
    run_program("load_store");
endtask

// Taken BEQ skips words 3 to 6, the second BEQ falls through
// Word 6 lies past the squash window, so only the redirect skips it
task automatic test_branch();
    prog.delete();
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0007));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'h0007));
    prog.push_back(enc_i(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'h0004));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd3, 5'd0, 16'h0001));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd4, 5'd0, 16'h0002));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd5, 5'd0, 16'h0003));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd3, 5'd0, 16'h0004));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd6, 5'd0, 16'h0009));
    prog.push_back(enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd6, 16'h0002));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd7, 5'd6, 16'h0001));
    prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd8, 5'd7, 5'd1));
    run_program("branch");
endtask

task automatic test_random();
    logic [2:0]          sel;
    mips_pkg::reg_addr_t rd;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    logic [15:0]         imm;
    prog.delete();
    for (int n = 0; n < 40; n++) begin
        sel = 3'(rand_bits(3));
        rd  = 5'(rand_bits(3));
        rs  = 5'(rand_bits(3));
        rt  = 5'(rand_bits(3));
        case (sel)
            3'd1: prog.push_back(enc_r(mips_pkg::FN_ADD, rd, rs, rt));
            3'd2: prog.push_back(enc_r(mips_pkg::FN_SUB, rd, rs, rt));
            3'd3: prog.push_back(enc_r(mips_pkg::FN_AND, rd, rs, rt));
            3'd4: prog.push_back(enc_r(mips_pkg::FN_OR, rd, rs, rt));
            3'd5: prog.push_back(enc_r(mips_pkg::FN_SLT, rd, rs, rt));
            default: begin
                imm = 16'(rand_bits(16));
                prog.push_back(enc_i(mips_pkg::OP_ADDI, rd, rs, imm));
            end
        endcase
    end
    run_program("random_alu");
endtask

task automatic test_reg_zero();
    prog.delete();
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd0, 16'h0037));
    prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0003));
    prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd0, 5'd1, 5'd1));
    prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd2, 5'd0, 5'd1));
    prog.push_back(enc_r(mips_pkg::FN_OR, 5'd3, 5'd0, 5'd0));
    prog.push_back(enc_r(mips_pkg::FN_SUB, 5'd4, 5'd1, 5'd0));
    run_program("reg_zero");
endtask

`endif

// File: tests/tb_top_mips.sv
module tb_top_mips;

    localparam int IMEM_DEPTH   = 256;
    localparam int DMEM_DEPTH   = 256;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_CYCLES  = 200;
    localparam int QUIET_CYCLES = 20;
    localparam int MODEL_STEPS  = 1000;

    logic                i_clk;
    logic                i_rst;
    logic                i_imem_we;
    mips_pkg::word_t     i_imem_addr;
    mips_pkg::word_t     i_imem_data;
    logic                o_wb_valid;
    mips_pkg::reg_addr_t o_wb_reg;
    mips_pkg::word_t     o_wb_data;

    int                  errors;
    int                  pass_count;
    int                  fail_count;
    logic [15:0]         lfsr_state;
    mips_pkg::word_t     prog [$];
    mips_pkg::reg_addr_t exp_reg [$];
    mips_pkg::word_t     exp_data [$];

    top_mips #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) DUT (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_wb_valid  (o_wb_valid),
        .o_wb_reg    (o_wb_reg),
        .o_wb_data   (o_wb_data)
    );

    always #4 i_clk = !i_clk;

    // ----------------------------------------
    // Instruction encoders
    // ----------------------------------------
    function automatic mips_pkg::word_t enc_r(mips_pkg::funct_t fn, mips_pkg::reg_addr_t rd,
                                              mips_pkg::reg_addr_t rs, mips_pkg::reg_addr_t rt);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t enc_i(mips_pkg::opcode_t op, mips_pkg::reg_addr_t rt,
                                              mips_pkg::reg_addr_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ----------------------------------------
    // Architectural model, one instruction at a time
    // ----------------------------------------
    task automatic run_model();
        mips_pkg::word_t     regs [32];
        mips_pkg::word_t     dmem [mips_pkg::word_t];
        mips_pkg::word_t     pc;
        mips_pkg::word_t     instr;
        mips_pkg::word_t     imm;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     res;
        mips_pkg::reg_addr_t dst;
        logic                wr;
        int                  steps;
        exp_reg.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = '0;
        steps = 0;
        while ((pc >> 2) < prog.size() && steps < MODEL_STEPS) begin
            instr = prog[pc >> 2];
            imm   = {{16{instr[15]}}, instr[15:0]};
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            dst   = instr[20:16];
            wr    = 1'b0;
            res   = '0;
            pc    = pc + 32'd4;
            case (mips_pkg::opcode_t'(instr[31:26]))
                mips_pkg::OP_RTYPE: begin
                    wr  = 1'b1;
                    dst = instr[15:11];
                    case (mips_pkg::funct_t'(instr[5:0]))
                        mips_pkg::FN_ADD: res = a + b;
                        mips_pkg::FN_SUB: res = a - b;
                        mips_pkg::FN_AND: res = a & b;
                        mips_pkg::FN_OR:  res = a | b;
                        mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wr = 1'b0;
                    endcase
                end
                mips_pkg::OP_ADDI: begin
                    wr  = 1'b1;
                    res = a + imm;
                end
                mips_pkg::OP_LW: begin
                    wr  = 1'b1;
                    res = dmem.exists((a + imm) >> 2) ? dmem[(a + imm) >> 2] : 'x;
                end
                mips_pkg::OP_SW: dmem[(a + imm) >> 2] = b;
                // Target counts words from the next instruction
                mips_pkg::OP_BEQ: begin
                    if (a == b) begin
                        pc = pc + (imm << 2);
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = res;
                exp_reg.push_back(dst);
                exp_data.push_back(res);
            end
            steps++;
        end
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_word(string name, mips_pkg::word_t exp, mips_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(string name, mips_pkg::reg_addr_t exp, mips_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    `include "tb_tests.svh"

    initial begin
        i_clk       = 1'b0;
        i_rst       = 1'b0;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        errors      = 0;
        pass_count  = 0;
        fail_count  = 0;
        lfsr_state  = 16'd21969;
        test_reset_quiet();
        test_alu_chain();
        test_load_store();
        test_branch();
        test_random();
        test_reg_zero();
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: top_mips.f
+incdir+tests
rtl/mips_pkg.sv
rtl/instr_fetch.sv
rtl/pipe_control.sv
rtl/reg_file.sv
rtl/alu_execute.sv
rtl/data_memory.sv
rtl/top_mips.sv
tests/tb_top_mips.sv
